// ==== hdl/rob_params.svh ====
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// buffer geometry
`define ROB_DEPTH   64
`define ROB_IDX_W   6

// allocation and commit happen in aligned groups of four
`define ROB_GROUP   4
`define ROB_SLOT_W  2
`define ROB_CNT_W   3

// payload field widths
`define PREG_W      6
`define PC_W        16
`define COND_W      2

// multiplier, alu1, alu2, load
`define DONE_PORTS  4

`endif

// ==== hdl/rob_pkg.sv ====
`default_nettype none
`include "rob_params.svh"

package rob_pkg;

    // one instruction from the allocation stage
    typedef struct packed {
        logic               is_branch;
        logic               reg_wrt;
        logic               pred;
        logic [`COND_W-1:0] cond;
        logic [`PC_W-1:0]   rcvr_pc;
        logic [`PREG_W-1:0] free_preg;
    } alloc_slot_t;

    // slot 0 is the oldest and lands at the tail
    typedef struct packed {
        logic                         all_nop;
        alloc_slot_t [`ROB_GROUP-1:0] slot;
    } alloc_group_t;

    typedef struct packed {
        logic                  vld;
        logic [`ROB_IDX_W-1:0] idx;
    } done_port_t;

    // rslt of zero means no branch result this cycle
    typedef struct packed {
        logic [`ROB_IDX_W-1:0] idx;
        logic [`COND_W-1:0]    rslt;
    } brnc_res_t;

    typedef struct packed {
        logic                  mis_pred;
        logic                  cmt_brnc;
        logic [`ROB_IDX_W-1:0] idx;
        logic                  brnc_pred_log;
        logic [`PC_W-1:0]      rcvr_pc;
    } brnc_out_t;

    // freed registers in program order, slot 0 first
    typedef struct packed {
        logic [`ROB_CNT_W-1:0]                 cnt;
        logic [`ROB_GROUP-1:0][`PREG_W-1:0]    preg;
    } release_t;

    typedef struct packed {
        logic               pred;
        logic [`COND_W-1:0] cond;
        logic [`PC_W-1:0]   rcvr_pc;
    } brnc_view_t;

    typedef struct packed {
        logic [`COND_W+`PC_W-`PREG_W:0] pad;
        logic [`PREG_W-1:0]             free_preg;
    } reg_view_t;

    // an entry is a branch or a register writer, never both
    typedef union packed {
        brnc_view_t brnc;
        reg_view_t  regw;
    } rob_payload_u;

endpackage

`default_nettype wire

// ==== hdl/rob_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_params.svh"

module rob_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  alloc_en,
    input  logic                  mis_pred,
    input  logic [`ROB_IDX_W-1:0] brnc_idx,
    input  logic [`ROB_DEPTH-1:0] ready_vec,
    output logic [`ROB_IDX_W-1:0] head,
    output logic [`ROB_IDX_W-1:0] tail,
    output logic                  tail_wrap,
    output logic                  rob_full,
    output logic                  rob_empt,
    output logic [`ROB_CNT_W-1:0] commit_cnt,
    output logic                  alloc_go,
    output logic [`ROB_IDX_W-1:0] rollback_tail
);

    logic                  head_wrap;
    logic [`ROB_GROUP-1:0] head_rdy;
    logic [`ROB_IDX_W:0]   occupancy;

    // a mispredict wins over allocation in the same cycle
    assign alloc_go = alloc_en && !mis_pred;

    assign rob_empt = (head == tail) && (head_wrap == tail_wrap);
    assign rob_full = (head == tail) && (head_wrap != tail_wrap);

    assign occupancy = {tail_wrap, tail} - {head_wrap, head};

    // first group boundary after the branch's own group
    assign rollback_tail = {brnc_idx[`ROB_IDX_W-1:`ROB_SLOT_W] + 1'b1, {`ROB_SLOT_W{1'b0}}};

    always_comb begin
        for (int k = 0; k < `ROB_GROUP; k++) begin
            head_rdy[k] = ready_vec[head + `ROB_IDX_W'(k)];
        end
    end

    // leading run of ready entries at the head
    always_comb begin
        commit_cnt = `ROB_CNT_W'(`ROB_GROUP);
        for (int k = `ROB_GROUP - 1; k >= 0; k--) begin
            if (!head_rdy[k]) begin
                commit_cnt = `ROB_CNT_W'(k);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head      <= '0;
            head_wrap <= 1'b0;
        end else begin
            {head_wrap, head} <= {head_wrap, head}
                + {{(`ROB_IDX_W + 1 - `ROB_CNT_W){1'b0}}, commit_cnt};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tail      <= '0;
            tail_wrap <= 1'b0;
        end else if (mis_pred) begin
            tail <= rollback_tail;
            // stepping back across entry 0 undoes a wrap
            if (rollback_tail > tail) begin
                tail_wrap <= !tail_wrap;
            end
        end else if (alloc_go) begin
            {tail_wrap, tail} <= {tail_wrap, tail} + (`ROB_IDX_W + 1)'(`ROB_GROUP);
        end
    end

    // the front end must stall on rob_full
    a_no_alloc_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_go |-> !rob_full
    );

    // ready entries never run past the tail
    a_commit_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        {{(`ROB_IDX_W + 1 - `ROB_CNT_W){1'b0}}, commit_cnt} <= occupancy
    );

endmodule

`default_nettype wire

// ==== hdl/rob_status_array.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_params.svh"

module rob_status_array
    import rob_pkg::*;
(
    input  logic                               clk,
    input  logic                               rst_n,
    input  alloc_group_t                       alloc,
    input  logic                               alloc_go,
    input  logic [`ROB_IDX_W-1:0]              tail,
    input  logic [`ROB_IDX_W-1:0]              head,
    input  logic [`ROB_CNT_W-1:0]              commit_cnt,
    input  done_port_t [`DONE_PORTS-1:0]       done_ports,
    input  logic                               cmt_brnc,
    input  logic                               mis_pred,
    input  logic [`ROB_IDX_W-1:0]              brnc_idx,
    input  logic [`ROB_IDX_W-1:0]              rollback_tail,
    output logic [`ROB_DEPTH-1:0]              ready_vec,
    output logic [`ROB_DEPTH-1:0]              branch_vec,
    output logic [`ROB_DEPTH-1:0]              wrt_vec,
    output logic [`ROB_DEPTH-1:0]              squash_vec
);

    logic [`ROB_DEPTH-1:0] vld_q;
    logic [`ROB_DEPTH-1:0] done_q;
    logic [`ROB_DEPTH-1:0] need_q;
    logic [`ROB_DEPTH-1:0] done_hit;
    logic [`ROB_DEPTH-1:0] alloc_mask;
    logic [`ROB_DEPTH-1:0] commit_mask;
    logic [`ROB_DEPTH-1:0] squash_mask;
    logic [`ROB_DEPTH-1:0] inval_mask;
    logic [`ROB_IDX_W-1:0] inval_len;

    assign ready_vec = vld_q & (done_q | ~need_q);

    // entries from the rollback point up to the old tail are discarded
    assign inval_len = tail - rollback_tail;

    for (genvar i = 0; i < `ROB_DEPTH; i++) begin : g_range
        logic [`ROB_IDX_W-1:0] ent;
        logic [`ROB_IDX_W-1:0] head_ofs;
        logic [`ROB_IDX_W-1:0] inval_ofs;

        assign ent       = `ROB_IDX_W'(i);
        assign head_ofs  = ent - head;
        assign inval_ofs = ent - rollback_tail;

        assign alloc_mask[i]  = alloc_go
            && (ent[`ROB_IDX_W-1:`ROB_SLOT_W] == tail[`ROB_IDX_W-1:`ROB_SLOT_W]);
        assign commit_mask[i] = head_ofs < `ROB_IDX_W'(commit_cnt);
        // younger slots in the mispredicted branch's group
        assign squash_mask[i] = mis_pred
            && (ent[`ROB_IDX_W-1:`ROB_SLOT_W] == brnc_idx[`ROB_IDX_W-1:`ROB_SLOT_W])
            && (ent[`ROB_SLOT_W-1:0] > brnc_idx[`ROB_SLOT_W-1:0]);
        assign inval_mask[i]  = mis_pred && (inval_ofs < inval_len);
    end

    always_comb begin
        done_hit = '0;
        for (int p = 0; p < `DONE_PORTS; p++) begin
            if (done_ports[p].vld) begin
                done_hit[done_ports[p].idx] = 1'b1;
            end
        end
        // a resolved branch is done either way
        if (cmt_brnc || mis_pred) begin
            done_hit[brnc_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q      <= '0;
            done_q     <= '0;
            need_q     <= '0;
            branch_vec <= '0;
            wrt_vec    <= '0;
            squash_vec <= '0;
        end else begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (inval_mask[i] || commit_mask[i]) begin
                    vld_q[i]      <= 1'b0;
                    done_q[i]     <= 1'b0;
                    need_q[i]     <= 1'b0;
                    branch_vec[i] <= 1'b0;
                    wrt_vec[i]    <= 1'b0;
                    squash_vec[i] <= 1'b0;
                end else if (alloc_mask[i]) begin
                    vld_q[i]      <= 1'b1;
                    done_q[i]     <= 1'b0;
                    need_q[i]     <= alloc.slot[i % `ROB_GROUP].is_branch
                                     || alloc.slot[i % `ROB_GROUP].reg_wrt;
                    branch_vec[i] <= alloc.slot[i % `ROB_GROUP].is_branch;
                    wrt_vec[i]    <= alloc.slot[i % `ROB_GROUP].reg_wrt;
                    squash_vec[i] <= 1'b0;
                end else begin
                    if (done_hit[i] || squash_mask[i]) begin
                        done_q[i] <= 1'b1;
                    end
                    if (squash_mask[i]) begin
                        squash_vec[i] <= 1'b1;
                    end
                end
            end
        end
    end

    // execution units only finish instructions that are in flight
    for (genvar p = 0; p < `DONE_PORTS; p++) begin : g_done_chk
        a_done_on_valid: assert property (
            @(posedge clk) disable iff (!rst_n)
            done_ports[p].vld |-> vld_q[done_ports[p].idx]
        );
    end

endmodule

`default_nettype wire

// ==== hdl/rob_payload_ram.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_params.svh"

module rob_payload_ram
    import rob_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  alloc_group_t                   alloc,
    input  logic                           alloc_go,
    input  logic [`ROB_IDX_W-1:0]          tail,
    input  logic [`ROB_IDX_W-1:0]          brnc_idx,
    input  logic [`ROB_IDX_W-1:0]          head,
    output rob_payload_u                   brnc_payload,
    output rob_payload_u [`ROB_GROUP-1:0]  head_payload
);

    rob_payload_u mem [`ROB_DEPTH];

    // branches keep prediction and recovery pc, writers keep the freed register
    function automatic rob_payload_u pack_slot(input alloc_slot_t s);
        rob_payload_u p;
        if (s.is_branch) begin
            p.brnc.pred    = s.pred;
            p.brnc.cond    = s.cond;
            p.brnc.rcvr_pc = s.rcvr_pc;
        end else begin
            p.regw.pad       = '0;
            p.regw.free_preg = s.free_preg;
        end
        return p;
    endfunction

    always_ff @(posedge clk) begin
        if (alloc_go) begin
            for (int g = 0; g < `ROB_GROUP; g++) begin
                mem[tail + `ROB_IDX_W'(g)] <= pack_slot(alloc.slot[g]);
            end
        end
    end

    assign brnc_payload = mem[brnc_idx];

    // commit window
    always_comb begin
        for (int k = 0; k < `ROB_GROUP; k++) begin
            head_payload[k] = mem[head + `ROB_IDX_W'(k)];
        end
    end

    // group writes rely on the control keeping the tail aligned
    a_tail_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        alloc_go |-> (tail[`ROB_SLOT_W-1:0] == '0)
    );

endmodule

`default_nettype wire

// ==== hdl/rob_branch_check.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_params.svh"

module rob_branch_check
    import rob_pkg::*;
(
    input  brnc_res_t             brnc_res,
    input  rob_payload_u          brnc_payload,
    input  logic [`ROB_DEPTH-1:0] branch_vec,
    output brnc_out_t             brnc_out
);

    logic present;
    logic taken;

    // result only counts against an entry holding a branch
    assign present = (brnc_res.rslt != '0) && branch_vec[brnc_res.idx];
    assign taken   = (brnc_payload.brnc.cond == brnc_res.rslt);

    always_comb begin
        brnc_out     = '0;
        brnc_out.idx = brnc_res.idx;
        if (present) begin
            brnc_out.mis_pred      = (brnc_payload.brnc.pred != taken);
            brnc_out.cmt_brnc      = (brnc_payload.brnc.pred == taken);
            brnc_out.brnc_pred_log = brnc_payload.brnc.pred;
            brnc_out.rcvr_pc       = brnc_payload.brnc.rcvr_pc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_release_pack.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_params.svh"

module rob_release_pack
    import rob_pkg::*;
(
    input  logic [`ROB_IDX_W-1:0]         head,
    input  logic [`ROB_CNT_W-1:0]         commit_cnt,
    input  rob_payload_u [`ROB_GROUP-1:0] head_payload,
    input  logic [`ROB_DEPTH-1:0]         wrt_vec,
    input  logic [`ROB_DEPTH-1:0]         squash_vec,
    output release_t                      release_o
);

    logic [`ROB_GROUP-1:0] give;

    // committing writers that survived the mispredict
    always_comb begin
        for (int k = 0; k < `ROB_GROUP; k++) begin
            give[k] = (`ROB_CNT_W'(k) < commit_cnt)
                      && wrt_vec[head + `ROB_IDX_W'(k)]
                      && !squash_vec[head + `ROB_IDX_W'(k)];
        end
    end

    // compact into the low slots, oldest first
    always_comb begin
        release_o = '0;
        for (int k = 0; k < `ROB_GROUP; k++) begin
            if (give[k]) begin
                release_o.preg[release_o.cnt[`ROB_SLOT_W-1:0]] = head_payload[k].regw.free_preg;
                release_o.cnt = release_o.cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rob_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_params.svh"

module rob_top
    import rob_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  alloc_group_t                  alloc,
    input  done_port_t [`DONE_PORTS-1:0]  done_ports,
    input  brnc_res_t                     brnc_res,
    output logic [`ROB_IDX_W:0]           next_idx,
    output logic                          rob_full,
    output logic                          rob_empt,
    output brnc_out_t                     brnc_out,
    output release_t                      release_o
);

    logic [`ROB_IDX_W-1:0]         head;
    logic [`ROB_IDX_W-1:0]         tail;
    logic                          tail_wrap;
    logic [`ROB_CNT_W-1:0]         commit_cnt;
    logic                          alloc_go;
    logic [`ROB_IDX_W-1:0]         rollback_tail;
    logic [`ROB_DEPTH-1:0]         ready_vec;
    logic [`ROB_DEPTH-1:0]         branch_vec;
    logic [`ROB_DEPTH-1:0]         wrt_vec;
    logic [`ROB_DEPTH-1:0]         squash_vec;
    rob_payload_u                  brnc_payload;
    rob_payload_u [`ROB_GROUP-1:0] head_payload;

    // allocation index seen by the front end
    assign next_idx = {tail_wrap, tail};

    rob_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc_en      (!alloc.all_nop),
        .mis_pred      (brnc_out.mis_pred),
        .brnc_idx      (brnc_res.idx),
        .ready_vec     (ready_vec),
        .head          (head),
        .tail          (tail),
        .tail_wrap     (tail_wrap),
        .rob_full      (rob_full),
        .rob_empt      (rob_empt),
        .commit_cnt    (commit_cnt),
        .alloc_go      (alloc_go),
        .rollback_tail (rollback_tail)
    );

    rob_status_array u_status (
        .clk           (clk),
        .rst_n         (rst_n),
        .alloc         (alloc),
        .alloc_go      (alloc_go),
        .tail          (tail),
        .head          (head),
        .commit_cnt    (commit_cnt),
        .done_ports    (done_ports),
        .cmt_brnc      (brnc_out.cmt_brnc),
        .mis_pred      (brnc_out.mis_pred),
        .brnc_idx      (brnc_res.idx),
        .rollback_tail (rollback_tail),
        .ready_vec     (ready_vec),
        .branch_vec    (branch_vec),
        .wrt_vec       (wrt_vec),
        .squash_vec    (squash_vec)
    );

    rob_payload_ram u_payload (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc        (alloc),
        .alloc_go     (alloc_go),
        .tail         (tail),
        .brnc_idx     (brnc_res.idx),
        .head         (head),
        .brnc_payload (brnc_payload),
        .head_payload (head_payload)
    );

    rob_branch_check u_brnc (
        .brnc_res     (brnc_res),
        .brnc_payload (brnc_payload),
        .branch_vec   (branch_vec),
        .brnc_out     (brnc_out)
    );

    rob_release_pack u_release (
        .head         (head),
        .commit_cnt   (commit_cnt),
        .head_payload (head_payload),
        .wrt_vec      (wrt_vec),
        .squash_vec   (squash_vec),
        .release_o    (release_o)
    );

endmodule

`default_nettype wire

// ==== bench/rob_tb_table.svh ====
`ifndef ROB_TB_TABLE_SVH
`define ROB_TB_TABLE_SVH

// one row per cycle
// columns: alloc, done strobes, branch result,
//          next_idx, rob_full, rob_empt, brnc_out, release_o
task automatic build_table();
    alloc_group_t fill;
    alloc_group_t first_fill;

    // writers at 0..3 completed in the order 2, 0, 3, 1
    add_row(group4(writer(10), writer(11), writer(12), writer(13)), '0, '0,
            7'd0, 1'b0, 1'b1, '0, '0);
    add_row(idle(), done_at(2), '0, 7'd4, 1'b0, 1'b0, '0, '0);
    add_row(idle(), done_at(0), '0, 7'd4, 1'b0, 1'b0, '0, '0);
    add_row(idle(), done_at(3), '0, 7'd4, 1'b0, 1'b0, '0, exp_rel(1, 10, 0, 0, 0));
    add_row(idle(), done_at(1), '0, 7'd4, 1'b0, 1'b0, '0, '0);
    add_row(idle(), '0, '0, 7'd4, 1'b0, 1'b0, '0, exp_rel(3, 11, 12, 13, 0));

    // plain slots retire without any strobe
    add_row(group4(plain(), plain(), plain(), plain()), '0, '0, 7'd4, 1'b0, 1'b1, '0, '0);
    add_row(idle(), '0, '0, 7'd8, 1'b0, 1'b0, '0, '0);

    // correctly predicted branch at entry 9
    add_row(group4(plain(), branch(1'b1, 2'd2, 16'h1234), writer(20), plain()), '0, '0,
            7'd8, 1'b0, 1'b1, '0, '0);
    add_row(idle(), done_at(10), res(9, 2), 7'd12, 1'b0, 1'b0,
            exp_brnc(1'b0, 1'b1, 9, 1'b1, 16'h1234), '0);
    add_row(idle(), '0, '0, 7'd12, 1'b0, 1'b0, '0, exp_rel(1, 20, 0, 0, 0));

    // mispredict at entry 13, group 16 and the same-cycle allocation are lost
    add_row(group4(writer(30), branch(1'b0, 2'd1, 16'hbeef), writer(31), writer(32)), '0, '0,
            7'd12, 1'b0, 1'b1, '0, '0);
    // plain group 16 would retire on its own if it stayed valid
    add_row(group4(plain(), plain(), plain(), plain()), '0, '0,
            7'd16, 1'b0, 1'b0, '0, '0);
    add_row(group4(writer(50), writer(51), writer(52), writer(53)), '0, res(13, 1),
            7'd20, 1'b0, 1'b0, exp_brnc(1'b1, 1'b0, 13, 1'b0, 16'hbeef), '0);
    add_row(idle(), done_at(12), '0, 7'd16, 1'b0, 1'b0, '0, '0);
    add_row(idle(), '0, '0, 7'd16, 1'b0, 1'b0, '0, exp_rel(1, 30, 0, 0, 0));

    // fill every group, nothing completes until the buffer is full
    for (int g = 0; g < `ROB_DEPTH / `ROB_GROUP; g++) begin
        fill = group4(writer(rand_preg()), writer(rand_preg()), writer(rand_preg()),
                      writer(rand_preg()));
        if (g == 0) begin
            first_fill = fill;
        end
        add_row(fill, '0, '0, 7'(16 + 4 * g), 1'b0, 1'(g == 0), '0, '0);
    end
    add_row(idle(), done_four(16), '0, 7'd80, 1'b1, 1'b0, '0, '0);
    add_row(idle(), '0, '0, 7'd80, 1'b1, 1'b0, '0,
            exp_rel(4, first_fill.slot[0].free_preg, first_fill.slot[1].free_preg,
                    first_fill.slot[2].free_preg, first_fill.slot[3].free_preg));
    add_row(idle(), '0, '0, 7'd80, 1'b0, 1'b0, '0, '0);
endtask

`endif

// ==== bench/rob_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "rob_params.svh"

module rob_tb
    import rob_pkg::*;
();

    typedef done_port_t [`DONE_PORTS-1:0] done_vec_t;

    // one cycle of stimulus followed by the expected outputs
    typedef struct packed {
        alloc_group_t        alloc;
        done_vec_t           done;
        brnc_res_t           res;
        logic [`ROB_IDX_W:0] next_idx;
        logic                full;
        logic                empt;
        brnc_out_t           brnc;
        release_t            rel;
    } row_t;

    logic                clk;
    logic                rst_n;
    alloc_group_t        alloc;
    done_vec_t           done_ports;
    brnc_res_t           brnc_res;
    logic [`ROB_IDX_W:0] next_idx;
    logic                rob_full;
    logic                rob_empt;
    brnc_out_t           brnc_out;
    release_t            release_o;

    row_t rows[$];
    int   cur_row;
    int   cycle_cnt;
    logic table_ready;

    rob_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (alloc),
        .done_ports (done_ports),
        .brnc_res   (brnc_res),
        .next_idx   (next_idx),
        .rob_full   (rob_full),
        .rob_empt   (rob_empt),
        .brnc_out   (brnc_out),
        .release_o  (release_o)
    );

    function automatic logic [`PREG_W-1:0] rand_preg();
        logic [31:0] r;
        r = $urandom;
        return r[`PREG_W-1:0];
    endfunction

    function automatic alloc_slot_t writer(input logic [`PREG_W-1:0] preg);
        alloc_slot_t s;
        s = '0;
        s.reg_wrt   = 1'b1;
        s.free_preg = preg;
        return s;
    endfunction

    // no branch, no register write, so the preg field is junk
    function automatic alloc_slot_t plain();
        alloc_slot_t s;
        s = '0;
        s.free_preg = rand_preg();
        return s;
    endfunction

    function automatic alloc_slot_t branch(input logic pred, input logic [`COND_W-1:0] cond,
                                           input logic [`PC_W-1:0] pc);
        alloc_slot_t s;
        s = '0;
        s.is_branch = 1'b1;
        s.pred      = pred;
        s.cond      = cond;
        s.rcvr_pc   = pc;
        return s;
    endfunction

    // s0 is the oldest slot
    function automatic alloc_group_t group4(input alloc_slot_t s0, input alloc_slot_t s1,
                                            input alloc_slot_t s2, input alloc_slot_t s3);
        alloc_group_t g;
        g.all_nop = 1'b0;
        g.slot[0] = s0;
        g.slot[1] = s1;
        g.slot[2] = s2;
        g.slot[3] = s3;
        return g;
    endfunction

    function automatic alloc_group_t idle();
        alloc_group_t g;
        g = '0;
        g.all_nop = 1'b1;
        return g;
    endfunction

    // single completion on the multiplier port
    function automatic done_vec_t done_at(input int idx);
        done_vec_t d;
        d = '0;
        d[0].vld = 1'b1;
        d[0].idx = idx[`ROB_IDX_W-1:0];
        return d;
    endfunction

    // whole group completes at once, one entry per port
    function automatic done_vec_t done_four(input int base);
        done_vec_t d;
        for (int p = 0; p < `DONE_PORTS; p++) begin
            d[p].vld = 1'b1;
            d[p].idx = `ROB_IDX_W'(base + p);
        end
        return d;
    endfunction

    function automatic brnc_res_t res(input int idx, input int rslt);
        brnc_res_t b;
        b.idx  = idx[`ROB_IDX_W-1:0];
        b.rslt = rslt[`COND_W-1:0];
        return b;
    endfunction

    function automatic brnc_out_t exp_brnc(input logic mis, input logic cmt, input int idx,
                                           input logic pred_log, input logic [`PC_W-1:0] pc);
        brnc_out_t o;
        o.mis_pred      = mis;
        o.cmt_brnc      = cmt;
        o.idx           = idx[`ROB_IDX_W-1:0];
        o.brnc_pred_log = pred_log;
        o.rcvr_pc       = pc;
        return o;
    endfunction

    function automatic release_t exp_rel(input int cnt, input logic [`PREG_W-1:0] p0,
                                         input logic [`PREG_W-1:0] p1,
                                         input logic [`PREG_W-1:0] p2,
                                         input logic [`PREG_W-1:0] p3);
        release_t r;
        r.cnt     = cnt[`ROB_CNT_W-1:0];
        r.preg[0] = p0;
        r.preg[1] = p1;
        r.preg[2] = p2;
        r.preg[3] = p3;
        return r;
    endfunction

    task automatic add_row(input alloc_group_t a, input done_vec_t d, input brnc_res_t b,
                           input logic [`ROB_IDX_W:0] nidx, input logic full,
                           input logic empt, input brnc_out_t bo, input release_t rl);
        row_t r;
        r.alloc    = a;
        r.done     = d;
        r.res      = b;
        r.next_idx = nidx;
        r.full     = full;
        r.empt     = empt;
        r.brnc     = bo;
        r.rel      = rl;
        rows.push_back(r);
    endtask

    `include "rob_tb_table.svh"

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] row %0d %s got 0x%0h expected 0x%0h", cur_row, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic check_row(input row_t r);
        check_value("next_idx", next_idx, r.next_idx);
        check_value("rob_full", rob_full, r.full);
        check_value("rob_empt", rob_empt, r.empt);
        check_value("brnc_out.mis_pred", brnc_out.mis_pred, r.brnc.mis_pred);
        check_value("brnc_out.cmt_brnc", brnc_out.cmt_brnc, r.brnc.cmt_brnc);
        check_value("brnc_out.idx", brnc_out.idx, r.brnc.idx);
        check_value("brnc_out.brnc_pred_log", brnc_out.brnc_pred_log, r.brnc.brnc_pred_log);
        check_value("brnc_out.rcvr_pc", brnc_out.rcvr_pc, r.brnc.rcvr_pc);
        check_value("release_o.cnt", release_o.cnt, r.rel.cnt);
        check_value("release_o.preg", release_o.preg, r.rel.preg);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        wait (table_ready);
        while (cycle_cnt <= rows.size() + 20) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, run went past %0d cycles", rows.size() + 20);
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        int unsigned seed_dummy;
        seed_dummy  = $urandom(90602);
        table_ready = 1'b0;
        rst_n       = 1'b0;
        alloc       = idle();
        done_ports  = '0;
        brnc_res    = '0;
        cur_row     = 0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #2 rst_n = 1'b1;
        foreach (rows[i]) begin
            @(posedge clk);
            #2;
            cur_row    = i;
            alloc      = rows[i].alloc;
            done_ports = rows[i].done;
            brnc_res   = rows[i].res;
            // sample just ahead of the next edge
            #36;
            check_row(rows[i]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rob.f ====
+incdir+hdl
+incdir+bench
hdl/rob_pkg.sv
hdl/rob_ctrl.sv
hdl/rob_status_array.sv
hdl/rob_payload_ram.sv
hdl/rob_branch_check.sv
hdl/rob_release_pack.sv
hdl/rob_top.sv
bench/rob_tb.sv

// ==== Bender.yml ====
package:
  name: rob

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rob_pkg.sv
      - hdl/rob_ctrl.sv
      - hdl/rob_status_array.sv
      - hdl/rob_payload_ram.sv
      - hdl/rob_branch_check.sv
      - hdl/rob_release_pack.sv
      - hdl/rob_top.sv
  - target: test
    include_dirs:
      - hdl
      - bench
    files:
      - bench/rob_tb.sv
